// File: common/simt_alu_cfg.svh
`ifndef SIMT_ALU_CFG_SVH
`define SIMT_ALU_CFG_SVH

// Lanes per warp
`define NUM_THREADS 4

// Warp id width
`define NW_BITS 2

// Destination register index width
`define NR_BITS 5

// Multiplier pipeline depth in stages
`define MUL_LATENCY 2

`endif

// File: common/simt_alu_pkg.sv
`default_nettype none

package simt_alu_pkg;

    typedef logic [31:0] word_t;

    // How op_type is interpreted
    typedef enum logic [1:0] {
        MOD_ALU = 2'd0,
        MOD_BR  = 2'd1,
        MOD_MUL = 2'd2
    } op_mod_e;

    // Bits [3:2] give the result class, bit 0 the signedness
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLTU = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1001,
        ALU_SUB  = 4'b1011,
        ALU_AND  = 4'b1100,
        ALU_OR   = 4'b1101,
        ALU_XOR  = 4'b1110,
        ALU_SLL  = 4'b1111
    } alu_op_e;

    // Shares the lane compare encoding, so LT lands on SLT and LTU on SLTU
    typedef enum logic [3:0] {
        BR_EQ   = 4'b0000,
        BR_NE   = 4'b0010,
        BR_LTU  = 4'b0100,
        BR_LT   = 4'b0101,
        BR_GEU  = 4'b0110,
        BR_GE   = 4'b0111,
        BR_JAL  = 4'b1000,
        BR_JALR = 4'b1001
    } br_op_e;

    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHSU = 2'd2,
        MUL_MULHU  = 2'd3
    } mul_op_e;

    function automatic logic br_neg(br_op_e op);
        return op[1];
    endfunction

    function automatic logic br_less(br_op_e op);
        return op[2];
    endfunction

    // Jumps are always taken
    function automatic logic br_static(br_op_e op);
        return op[3];
    endfunction

endpackage

`default_nettype wire

// File: alu_unit/alu_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "simt_alu_cfg.svh"

module alu_lane
    import simt_alu_pkg::*;
(
    input  alu_op_e alu_op,
    input  logic    is_br,
    input  logic    use_pc,
    input  logic    use_imm,
    input  word_t   pc,
    input  word_t   imm,
    input  word_t   rs1,
    input  word_t   rs2,
    output word_t   add_result,
    output logic    less,
    output logic    equal,
    output word_t   result
);

    logic        is_signed;
    logic [1:0]  op_class;
    word_t       in1_pc;
    word_t       in2_imm;
    word_t       in2_cmp;
    logic [32:0] sub_in1;
    logic [32:0] sub_in2;
    logic [32:0] sub_result;
    logic [32:0] shr_in;
    word_t       shr_result;
    word_t       misc_result;

    assign is_signed = alu_op[0];
    assign op_class  = alu_op[3:2];

    assign in1_pc  = use_pc ? pc : rs1;
    assign in2_imm = use_imm ? imm : rs2;
    // Branches compare rs1 with rs2 and keep the immediate for the target adder
    assign in2_cmp = (use_imm && !is_br) ? imm : rs2;

    assign add_result = in1_pc + in2_imm;

    assign sub_in1    = {is_signed & rs1[31], rs1};
    assign sub_in2    = {is_signed & in2_cmp[31], in2_cmp};
    assign sub_result = $signed(sub_in1) - $signed(sub_in2);

    assign less  = sub_result[32];
    assign equal = (sub_result[31:0] == 32'd0);

    // Extra top bit makes one shifter serve SRA and SRL
    assign shr_in     = {is_signed & rs1[31], rs1};
    assign shr_result = 32'($signed(shr_in) >>> in2_imm[4:0]);

    always_comb begin
        case (alu_op)
            ALU_AND: misc_result = rs1 & in2_imm;
            ALU_OR:  misc_result = rs1 | in2_imm;
            ALU_XOR: misc_result = rs1 ^ in2_imm;
            default: misc_result = rs1 << in2_imm[4:0];
        endcase
    end

    always_comb begin
        case (op_class)
            2'b00:   result = add_result;
            2'b01:   result = {31'b0, less};
            2'b10:   result = (alu_op == ALU_SUB) ? sub_result[31:0] : shr_result;
            default: result = misc_result;
        endcase
    end

endmodule

`default_nettype wire

// File: alu_unit/mul_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "simt_alu_cfg.svh"

module mul_pipe
    import simt_alu_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           valid_in,
    output logic                           ready_in,
    input  mul_op_e                        mul_op,
    input  logic [`NW_BITS-1:0]            wid_in,
    input  logic [`NUM_THREADS-1:0]        tmask_in,
    input  word_t                          pc_in,
    input  logic [`NR_BITS-1:0]            rd_in,
    input  logic                           wb_in,
    input  word_t [`NUM_THREADS-1:0]       rs1_in,
    input  word_t [`NUM_THREADS-1:0]       rs2_in,
    output logic                           valid_out,
    input  logic                           ready_out,
    output logic [`NW_BITS-1:0]            wid_out,
    output logic [`NUM_THREADS-1:0]        tmask_out,
    output word_t                          pc_out,
    output logic [`NR_BITS-1:0]            rd_out,
    output logic                           wb_out,
    output word_t [`NUM_THREADS-1:0]       data_out
);

    logic                          s1_valid;
    mul_op_e                       s1_op;
    logic [`NW_BITS-1:0]           s1_wid;
    logic [`NUM_THREADS-1:0]       s1_tmask;
    word_t                         s1_pc;
    logic [`NR_BITS-1:0]           s1_rd;
    logic                          s1_wb;
    logic [`NUM_THREADS-1:0][32:0] s1_a;
    logic [`NUM_THREADS-1:0][32:0] s1_b;
    logic                          s1_en;
    logic                          s2_en;
    logic                          a_signed;
    logic                          b_signed;
    word_t [`NUM_THREADS-1:0]      mul_res;

    // A stage moves when the one after it is empty or moving
    assign s2_en    = !valid_out || ready_out;
    assign s1_en    = !s1_valid || s2_en;
    assign ready_in = s1_en;

    assign a_signed = (mul_op == MUL_MULH) || (mul_op == MUL_MULHSU);
    assign b_signed = (mul_op == MUL_MULH);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (s1_en) begin
            s1_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_en) begin
            s1_op    <= mul_op;
            s1_wid   <= wid_in;
            s1_tmask <= tmask_in;
            s1_pc    <= pc_in;
            s1_rd    <= rd_in;
            s1_wb    <= wb_in;
            for (int i = 0; i < `NUM_THREADS; i++) begin
                s1_a[i] <= {a_signed & rs1_in[i][31], rs1_in[i]};
                s1_b[i] <= {b_signed & rs2_in[i][31], rs2_in[i]};
            end
        end
    end

    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_mul
        logic [63:0] prod;
        assign prod       = $signed(s1_a[i]) * $signed(s1_b[i]);
        // Only plain MUL keeps the low half
        assign mul_res[i] = (s1_op == MUL_MUL) ? prod[31:0] : prod[63:32];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else if (s2_en) begin
            valid_out <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_en) begin
            wid_out   <= s1_wid;
            tmask_out <= s1_tmask;
            pc_out    <= s1_pc;
            rd_out    <= s1_rd;
            wb_out    <= s1_wb;
            data_out  <= mul_res;
        end
    end

endmodule

`default_nettype wire

// File: alu_unit/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "simt_alu_cfg.svh"

module alu_unit
    import simt_alu_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [`NW_BITS-1:0]              req_wid,
    input  logic [`NUM_THREADS-1:0]          req_tmask,
    input  word_t                            req_pc,
    input  word_t                            req_next_pc,
    input  logic [1:0]                       req_op_mod,
    input  logic [3:0]                       req_op_type,
    input  logic                             req_use_pc,
    input  logic                             req_use_imm,
    input  word_t                            req_imm,
    input  logic [$clog2(`NUM_THREADS)-1:0]  req_tid,
    input  logic [`NR_BITS-1:0]              req_rd,
    input  logic                             req_wb,
    input  word_t [`NUM_THREADS-1:0]         req_rs1_data,
    input  word_t [`NUM_THREADS-1:0]         req_rs2_data,

    output logic                             commit_valid,
    input  logic                             commit_ready,
    output logic [`NW_BITS-1:0]              commit_wid,
    output logic [`NUM_THREADS-1:0]          commit_tmask,
    output word_t                            commit_pc,
    output logic [`NR_BITS-1:0]              commit_rd,
    output logic                             commit_wb,
    output word_t [`NUM_THREADS-1:0]         commit_data,

    output logic                             br_valid,
    output logic [`NW_BITS-1:0]              br_wid,
    output logic                             br_taken,
    output word_t                            br_dest
);

    op_mod_e                       op_mod;
    alu_op_e                       alu_op;
    br_op_e                        br_op;
    mul_op_e                       mul_op;
    logic                          is_br_op;
    logic                          is_mul_op;
    logic                          is_jal;

    word_t [`NUM_THREADS-1:0]      lane_add;
    logic  [`NUM_THREADS-1:0]      lane_less;
    logic  [`NUM_THREADS-1:0]      lane_equal;
    word_t [`NUM_THREADS-1:0]      lane_result;
    word_t [`NUM_THREADS-1:0]      alu_data;

    logic                          taken_c;
    logic                          stall_out;

    logic                          mul_ready_in;
    logic                          mul_valid_out;
    logic                          mul_ready_out;
    logic [`NW_BITS-1:0]           mul_wid;
    logic [`NUM_THREADS-1:0]       mul_tmask;
    word_t                         mul_pc;
    logic [`NR_BITS-1:0]           mul_rd;
    logic                          mul_wb;
    word_t [`NUM_THREADS-1:0]      mul_data;

    logic                          result_valid;
    logic                          result_is_br;
    logic                          is_br_r;

    assign op_mod    = op_mod_e'(req_op_mod);
    assign alu_op    = alu_op_e'(req_op_type);
    assign br_op     = br_op_e'(req_op_type);
    assign mul_op    = mul_op_e'(req_op_type[1:0]);
    assign is_br_op  = (op_mod == MOD_BR);
    assign is_mul_op = (op_mod == MOD_MUL);

    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_lane
        alu_lane lane (
            .alu_op     (alu_op),
            .is_br      (is_br_op),
            .use_pc     (req_use_pc),
            .use_imm    (req_use_imm),
            .pc         (req_pc),
            .imm        (req_imm),
            .rs1        (req_rs1_data[i]),
            .rs2        (req_rs2_data[i]),
            .add_result (lane_add[i]),
            .less       (lane_less[i]),
            .equal      (lane_equal[i]),
            .result     (lane_result[i])
        );
    end

    // Jumps write the return address to every thread
    assign is_jal   = is_br_op && ((br_op == BR_JAL) || (br_op == BR_JALR));
    assign alu_data = is_jal ? {`NUM_THREADS{req_next_pc}} : lane_result;

    // Branch outcome comes from the thread picked by req_tid
    assign taken_c = ((br_less(br_op) ? lane_less[req_tid] : lane_equal[req_tid])
                      ^ br_neg(br_op)) | br_static(br_op);

    mul_pipe mul (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (req_valid && is_mul_op),
        .ready_in  (mul_ready_in),
        .mul_op    (mul_op),
        .wid_in    (req_wid),
        .tmask_in  (req_tmask),
        .pc_in     (req_pc),
        .rd_in     (req_rd),
        .wb_in     (req_wb),
        .rs1_in    (req_rs1_data),
        .rs2_in    (req_rs2_data),
        .valid_out (mul_valid_out),
        .ready_out (mul_ready_out),
        .wid_out   (mul_wid),
        .tmask_out (mul_tmask),
        .pc_out    (mul_pc),
        .rd_out    (mul_rd),
        .wb_out    (mul_wb),
        .data_out  (mul_data)
    );

    assign stall_out     = commit_valid && !commit_ready;
    assign mul_ready_out = !stall_out;

    // A finished multiply takes the output register ahead of lane results
    assign req_ready    = is_mul_op ? mul_ready_in : !(mul_valid_out || stall_out);
    assign result_valid = mul_valid_out || (req_valid && !is_mul_op);
    assign result_is_br = !mul_valid_out && is_br_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            is_br_r      <= 1'b0;
        end else if (!stall_out) begin
            commit_valid <= result_valid;
            is_br_r      <= result_is_br;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_out) begin
            commit_wid   <= mul_valid_out ? mul_wid   : req_wid;
            commit_tmask <= mul_valid_out ? mul_tmask : req_tmask;
            commit_pc    <= mul_valid_out ? mul_pc    : req_pc;
            commit_rd    <= mul_valid_out ? mul_rd    : req_rd;
            commit_wb    <= mul_valid_out ? mul_wb    : req_wb;
            commit_data  <= mul_valid_out ? mul_data  : alu_data;
            br_taken     <= taken_c;
            br_dest      <= lane_add[req_tid];
        end
    end

    // Strobe only on the commit handshake of a branch
    assign br_valid = commit_valid && commit_ready && is_br_r;
    assign br_wid   = commit_wid;

endmodule

`default_nettype wire

// File: verif/alu_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "simt_alu_cfg.svh"

module alu_unit_tb;

    localparam int NUM_CASES  = 34;
    localparam int CASE_WORDS = 17;
    localparam int TIMEOUT_CYCLES = NUM_CASES * 20 + 8;

    logic                                 clk;
    logic                                 rst;
    logic                                 req_valid;
    logic                                 req_ready;
    logic [`NW_BITS-1:0]                  req_wid;
    logic [`NUM_THREADS-1:0]              req_tmask;
    logic [31:0]                          req_pc;
    logic [31:0]                          req_next_pc;
    logic [1:0]                           req_op_mod;
    logic [3:0]                           req_op_type;
    logic                                 req_use_pc;
    logic                                 req_use_imm;
    logic [31:0]                          req_imm;
    logic [$clog2(`NUM_THREADS)-1:0]      req_tid;
    logic [`NR_BITS-1:0]                  req_rd;
    logic                                 req_wb;
    logic [`NUM_THREADS-1:0][31:0]        req_rs1_data;
    logic [`NUM_THREADS-1:0][31:0]        req_rs2_data;
    logic                                 commit_valid;
    logic                                 commit_ready;
    logic [`NW_BITS-1:0]                  commit_wid;
    logic [`NUM_THREADS-1:0]              commit_tmask;
    logic [31:0]                          commit_pc;
    logic [`NR_BITS-1:0]                  commit_rd;
    logic                                 commit_wb;
    logic [`NUM_THREADS-1:0][31:0]        commit_data;
    logic                                 br_valid;
    logic [`NW_BITS-1:0]                  br_wid;
    logic                                 br_taken;
    logic [31:0]                          br_dest;

    // Each case is ctrl, pc, next_pc, imm, rs1 x4, rs2 x4, expected data x4 and dest
    logic [31:0] cases_mem [0:NUM_CASES*CASE_WORDS-1];
    logic        seen [0:NUM_CASES-1];
    int          seen_total;
    int          check_errors;
    int          other_errors;
    logic [31:0] lfsr;

    logic                          held;
    logic [31:0]                   held_pc;
    logic [`NW_BITS-1:0]           held_wid;
    logic [`NUM_THREADS-1:0]       held_tmask;
    logic [`NR_BITS-1:0]           held_rd;
    logic                          held_wb;
    logic [`NUM_THREADS-1:0][31:0] held_data;

    alu_unit uut (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_wid      (req_wid),
        .req_tmask    (req_tmask),
        .req_pc       (req_pc),
        .req_next_pc  (req_next_pc),
        .req_op_mod   (req_op_mod),
        .req_op_type  (req_op_type),
        .req_use_pc   (req_use_pc),
        .req_use_imm  (req_use_imm),
        .req_imm      (req_imm),
        .req_tid      (req_tid),
        .req_rd       (req_rd),
        .req_wb       (req_wb),
        .req_rs1_data (req_rs1_data),
        .req_rs2_data (req_rs2_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_wid   (commit_wid),
        .commit_tmask (commit_tmask),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data),
        .br_valid     (br_valid),
        .br_wid       (br_wid),
        .br_taken     (br_taken),
        .br_dest      (br_dest)
    );

    always #2 clk = !clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] case_word(input int idx, input int w);
        return cases_mem[idx * CASE_WORDS + w];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic apply_case(input int idx);
        logic [31:0] ctrl;
        ctrl = case_word(idx, 0);
        req_op_mod  = ctrl[29:28];
        req_op_type = ctrl[27:24];
        req_use_pc  = ctrl[23];
        req_use_imm = ctrl[22];
        req_wb      = ctrl[21];
        req_tid     = ctrl[17:16];
        req_rd      = ctrl[12:8];
        req_wid     = ctrl[5:4];
        req_tmask   = ctrl[3:0];
        req_pc      = case_word(idx, 1);
        req_next_pc = case_word(idx, 2);
        req_imm     = case_word(idx, 3);
        for (int t = 0; t < `NUM_THREADS; t++) begin
            req_rs1_data[t] = case_word(idx, 4 + t);
            req_rs2_data[t] = case_word(idx, 8 + t);
        end
    endtask

    task automatic check_commit();
        int          idx;
        logic [31:0] ctrl;
        idx = -1;
        for (int i = 0; i < NUM_CASES; i++) begin
            if (case_word(i, 1) == commit_pc) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Commit with unknown pc %h", commit_pc);
            other_errors++;
        end else if (seen[idx]) begin
            $display("Case %0d committed more than once", idx);
            other_errors++;
        end else begin
            seen[idx] = 1'b1;
            seen_total++;
            ctrl = case_word(idx, 0);
            check_value("commit_wid", 32'(commit_wid), 32'(ctrl[5:4]));
            check_value("commit_tmask", 32'(commit_tmask), 32'(ctrl[3:0]));
            check_value("commit_rd", 32'(commit_rd), 32'(ctrl[12:8]));
            check_value("commit_wb", 32'(commit_wb), 32'(ctrl[21]));
            // Data of non-writing branches is don't care
            if (ctrl[21]) begin
                for (int t = 0; t < `NUM_THREADS; t++) begin
                    check_value($sformatf("commit_data[%0d]", t), commit_data[t],
                                case_word(idx, 12 + t));
                end
            end
            check_value("br_valid", 32'(br_valid), 32'(ctrl[29:28] == 2'd1));
            if (ctrl[29:28] == 2'd1) begin
                check_value("br_taken", 32'(br_taken), 32'(ctrl[20]));
                check_value("br_dest", br_dest, case_word(idx, 16));
                check_value("br_wid", 32'(br_wid), 32'(ctrl[5:4]));
            end
        end
    endtask

    // Random back-pressure on the commit port
    always @(posedge clk) begin
        #1;
        lfsr = lfsr_step(lfsr);
        commit_ready = lfsr[0];
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (held) begin
                check_value("commit_valid", 32'(commit_valid), 32'd1);
                check_value("commit_pc", commit_pc, held_pc);
                check_value("commit_wid", 32'(commit_wid), 32'(held_wid));
                check_value("commit_tmask", 32'(commit_tmask), 32'(held_tmask));
                check_value("commit_rd", 32'(commit_rd), 32'(held_rd));
                check_value("commit_wb", 32'(commit_wb), 32'(held_wb));
                for (int t = 0; t < `NUM_THREADS; t++) begin
                    check_value($sformatf("commit_data[%0d]", t), commit_data[t], held_data[t]);
                end
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end else begin
                check_value("br_valid", 32'(br_valid), 32'd0);
            end
            held       = commit_valid && !commit_ready;
            held_pc    = commit_pc;
            held_wid   = commit_wid;
            held_tmask = commit_tmask;
            held_rd    = commit_rd;
            held_wb    = commit_wb;
            held_data  = commit_data;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: not every case committed in time");
        $display("Check errors: %0d, other errors: %0d", check_errors, other_errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        lfsr         = 32'hac76;
        commit_ready = 1'b0;
        req_valid    = 1'b0;
        held         = 1'b0;
        seen_total   = 0;
        check_errors = 0;
        other_errors = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            seen[i] = 1'b0;
        end
        $readmemh("verif/alu_cases.hex", cases_mem);
        apply_case(0);

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("br_valid", 32'(br_valid), 32'd0);

        for (int i = 0; i < NUM_CASES; i++) begin
            @(posedge clk);
            #1;
            apply_case(i);
            req_valid = 1'b1;
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;

        wait (seen_total == NUM_CASES);
        // Let any duplicate commit show up
        repeat (10) @(posedge clk);

        $display("Check errors: %0d, other errors: %0d", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/alu_cases.hex
// ctrl(mod,op,flags pc/imm/wb/taken,tid,rd,wid,tmask) pc next_pc imm rs1[0..3] rs2[0..3]
// then expected data[0..3] and expected branch dest
0020011f 00000100 00000104 00000000 00000001 00000002 00000003 00000004 00000010 00000020 00000030 00000040 00000011 00000022 00000033 00000044 00000000
2020022f 00000104 00000108 00000000 00000003 ffffffff 12345678 80000000 00000007 00000002 00000010 00000002 00000015 fffffffe 23456780 00000000 00000000
2120033f 00000108 0000010c 00000000 00000003 ffffffff 12345678 80000000 00000007 00000002 00000010 00000002 00000000 ffffffff 00000001 ffffffff 00000000
0060041f 0000010c 00000110 00000100 00000001 00000002 00000003 ffffffff 00000000 00000000 00000000 00000000 00000101 00000102 00000103 000000ff 00000000
00e0052f 00000110 00000114 00001000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00001110 00001110 00001110 00001110 00000000
2220063f 00000114 00000118 00000000 ffffffff 00000003 80000000 00000002 ffffffff ffffffff 00000002 80000000 ffffffff 00000002 ffffffff 00000001 00000000
2320073f 00000118 0000011c 00000000 ffffffff 00000003 80000000 00000002 ffffffff ffffffff 00000002 80000000 fffffffe 00000002 00000001 00000001 00000000
0b20081f 0000011c 00000120 00000000 00000010 00000005 00000000 80000000 00000001 00000005 00000001 00000001 0000000f 00000000 ffffffff 7fffffff 00000000
0520092f 00000120 00000124 00000000 ffffffff 00000001 80000000 00000005 00000001 ffffffff 7fffffff 00000005 00000001 00000000 00000001 00000000 00000000
04200a2f 00000124 00000128 00000000 ffffffff 00000001 80000000 00000005 00000001 ffffffff 7fffffff 00000005 00000000 00000001 00000000 00000000 00000000
05600b3f 00000128 0000012c 00000000 ffffffff 00000000 00000001 80000000 ffffffff ffffffff ffffffff ffffffff 00000001 00000000 00000000 00000001 00000000
21200c1f 0000012c 00000130 00000000 ffffffff 00000003 80000000 00000002 ffffffff ffffffff 00000002 80000000 00000000 ffffffff ffffffff ffffffff 00000000
20200d1f 00000130 00000134 00000000 ffffffff 00000003 80000000 00000002 ffffffff ffffffff 00000002 80000000 00000001 fffffffd 00000000 00000000 00000000
08200e1f 00000134 00000138 00000000 80000000 f0000000 12345678 ffffffff 00000004 00000001 00000008 00000024 08000000 78000000 00123456 0fffffff 00000000
09200f1f 00000138 0000013c 00000000 80000000 f0000000 12345678 ffffffff 00000004 00000001 00000008 00000024 f8000000 f8000000 00123456 ffffffff 00000000
0f20102f 0000013c 00000140 00000000 00000001 00000003 12345678 ffffffff 0000001f 00000004 00000020 00000021 80000000 00000030 12345678 fffffffe 00000000
0960112f 00000140 00000144 0000001f 80000000 7fffffff ffff0000 00000001 00000000 00000000 00000000 00000000 ffffffff 00000000 ffffffff 00000000 00000000
0c20123f 00000144 00000148 00000000 ff00ff00 12345678 ffffffff 00000000 0f0f0f0f ffff0000 a5a5a5a5 ffffffff 0f000f00 12340000 a5a5a5a5 00000000 00000000
0d20133f 00000148 0000014c 00000000 ff00ff00 12345678 ffffffff 00000000 0f0f0f0f ffff0000 a5a5a5a5 ffffffff ff0fff0f ffff5678 ffffffff ffffffff 00000000
0e20143f 0000014c 00000150 00000000 ff00ff00 12345678 ffffffff 00000000 0f0f0f0f ffff0000 a5a5a5a5 ffffffff f00ff00f edcb5678 5a5a5a5a ffffffff 00000000
0e60151f 00000150 00000154 ffffffff 00000000 00000001 aaaaaaaa ffffffff 00000000 00000000 00000000 00000000 ffffffff fffffffe 55555555 00000000 00000000
0d601625 00000154 00000158 00000f00 00000001 00000002 00000003 00000004 00000000 00000000 00000000 00000000 00000f01 00000f02 00000f03 00000f04 00000000
10d0001f 00000158 0000015c 00000020 00000005 00000001 00000002 00000003 00000005 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000178
10c1002f 0000015c 00000160 00000020 00000005 00000001 00000002 00000003 00000005 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000017c
12c2003f 00000160 00000164 00000040 00000005 00000001 00000002 00000003 00000005 00000000 00000002 00000000 00000000 00000000 00000000 00000000 000001a0
12d3000f 00000164 00000168 fffffff0 00000005 00000001 00000002 00000003 00000005 00000000 00000002 00000000 00000000 00000000 00000000 00000000 00000154
15d0001f 00000168 0000016c 00000008 ffffffff 00000001 00000000 00000000 00000001 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000170
14c0001f 0000016c 00000170 00000008 ffffffff 00000001 00000000 00000000 00000001 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000174
17d1002f 00000170 00000174 00000100 ffffffff 00000001 00000000 00000000 00000001 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000270
16c1002f 00000174 00000178 00000100 ffffffff 00000001 00000000 00000000 00000001 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000274
18f0013f 00000178 0000017c 00000400 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000017c 0000017c 0000017c 0000017c 00000578
1972023f 0000017c 00000180 00000010 00001000 00002000 00003000 00004000 00000000 00000000 00000000 00000000 00000180 00000180 00000180 00000180 00003010
2020173f 00000180 00000184 00000000 00000003 ffffffff 12345678 80000000 00000007 00000002 00000010 00000002 00000015 fffffffe 23456780 00000000 00000000
00201801 00000184 00000188 00000000 00000001 00000002 00000003 00000004 00000010 00000020 00000030 00000040 00000011 00000022 00000033 00000044 00000000

// File: filelist.f
+incdir+common
common/simt_alu_pkg.sv
alu_unit/alu_lane.sv
alu_unit/mul_pipe.sv
alu_unit/alu_unit.sv
verif/alu_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the alu_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module alu_unit_tb \
    -o alu_unit_sim > build.log 2>&1 \
    && ./obj_dir/alu_unit_sim > sim.log 2>&1 \
    || { cat build.log; cat sim.log 2>/dev/null; echo "Simulation did not complete"; exit 1; }

cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
